//--- all.f
source/array_format_pkg.sv
source/bus_pkg.sv
source/task_memory.sv
source/task_scheduler.sv
source/compute_core.sv
source/result_dump.sv
source/core_array_top.sv
verification/core_array_tb.sv

//--- Makefile
obj_dir/Vcore_array_tb: all.f $(wildcard source/*.sv) $(wildcard verification/*.sv)
	verilator --binary --assert -f all.f --top-module core_array_tb -Mdir obj_dir

.PHONY: run clean

run: obj_dir/Vcore_array_tb
	@out=$$(./obj_dir/Vcore_array_tb); echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

//--- verification/core_array_tb.sv
`default_nettype none

module core_array_tb
	import array_format_pkg::*, bus_pkg::*;
();

	localparam int num_programs = 6;
	localparam int idle_cycles = 40; // Quiet window after the dump
	localparam int watchdog_cycles =
		num_programs * (tm_depth * 40 + 8 * tm_depth + idle_cycles + 2);

	logic clk;
	logic reset;
	logic run;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	wb_req_t sink_req;
	wb_rsp_t sink_rsp;

	logic [31:0] lfsr_state;
	logic [frame_width-1:0] program_words [tm_depth];
	int prog_len;
	logic [reg_width-1:0] model_r0 [num_cores];
	logic [wb_dat_width-1:0] dumped [num_cores];
	int ack_delay [num_cores];
	int write_count;

	core_array_top uut (
		.clk,
		.reset,
		.run,
		.host_req,
		.host_rsp,
		.sink_req,
		.sink_rsp
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hd0000001 : 32'h0);
		end
		return value;
	endfunction

	// Opcode in the top two bits, immediate below
	function automatic logic [reg_width-1:0] apply_insn(input logic [reg_width-1:0] value,
		input logic [insn_width-1:0] op);
		case (op[7:6])
			2'd1: return value + {2'b00, op[5:0]};
			2'd2: return value ^ {2'b00, op[5:0]};
			2'd3: return {value[6:0], 1'b0};
			default: return value;
		endcase
	endfunction

	// Tasks in order up to the first stop bit
	function automatic void run_model();
		control_frame_t cf;
		logic [frame_width-1:0] word;
		logic [tm_addr_width-1:0] ptr;
		logic done;
		ptr = '0;
		done = 1'b0;
		for (int i = 0; i < num_cores; i++) model_r0[i] = '0;
		while (!done) begin
			cf = control_frame_t'(program_words[ptr]);
			ptr = ptr + 1'b1;
			for (int i = 0; i < num_cores; i++) begin
				if (cf.init_mask[i]) model_r0[i] = cf.init_r0[i];
			end
			for (int f = 0; f < int'(cf.frame_count); f++) begin
				word = program_words[ptr];
				ptr = ptr + 1'b1;
				for (int i = 0; i < num_cores; i++) begin
					for (int p = 0; p < insn_parts; p++) begin
						if (cf.active_mask[i]) begin
							model_r0[i] = apply_insn(model_r0[i], word[8*p +: 8]);
						end
					end
				end
			end
			done = cf.stop;
		end
	endfunction

	task automatic build_program();
		control_frame_t cf;
		logic [1:0] fsel;
		int n_tasks;
		int n_frames;
		int cap;
		int ptr;
		n_tasks = 3 + int'(rand_bits(2) % 3);
		ptr = 0;
		for (int t = 0; t < n_tasks; t++) begin
			cap = tm_depth - 2 - ptr - 2 * (n_tasks - 1 - t); // Room for later tasks
			n_frames = 1 + int'(rand_bits(2) % 3);
			if (n_frames > cap) n_frames = cap;
			cf = '0;
			cf.frame_count = tm_addr_width'(n_frames);
			cf.active_mask = num_cores'(rand_bits(num_cores));
			cf.init_mask = cf.active_mask & num_cores'(rand_bits(num_cores));
			for (int i = 0; i < num_cores; i++) begin
				cf.init_r0[i] = reg_width'(rand_bits(reg_width));
			end
			fsel = 2'(rand_bits(2) % 3);
			cf.fence = fence_t'(fsel);
			cf.stop = (t == n_tasks - 1);
			if (cf.stop) cf.stop_addr = tm_addr_width'(ptr + 1 + n_frames); // Final frame
			program_words[tm_addr_width'(ptr)] = cf;
			ptr++;
			for (int f = 0; f < n_frames; f++) begin
				program_words[tm_addr_width'(ptr)] = 64'(rand_bits(32));
				ptr++;
			end
		end
		cf = '0;
		cf.stop = 1'b1;
		cf.stop_addr = tm_addr_width'(ptr); // Jumps to itself
		program_words[tm_addr_width'(ptr)] = cf;
		prog_len = ptr + 1;
	endtask

	// Called one time unit after a rising edge
	task automatic host_access(input logic we, input logic [wb_adr_width-1:0] adr,
		input logic [wb_dat_width-1:0] wdata, output logic [wb_dat_width-1:0] rdata);
		int waited;
		host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > 4) report_failure("Host access got no acknowledge");
		end while (!host_rsp.ack);
		rdata = host_rsp.dat_r;
		host_req = '0;
		@(posedge clk);
		#1;
		check("host_rsp.ack", 64'(host_rsp.ack), 64'd0); // Single ack per access
	endtask

	// Wishbone sink with per-write ack delay
	initial begin : sink_model
		int wait_left;
		sink_rsp = '0;
		write_count = 0;
		wait_left = -1;
		forever begin
			@(posedge clk);
			if (reset) write_count = 0;
			#1;
			if (sink_rsp.ack) begin
				sink_rsp.ack = 1'b0;
			end else if (sink_req.cyc && sink_req.stb) begin
				if (wait_left < 0) begin
					wait_left = (write_count < num_cores) ?
						ack_delay[core_idx_width'(write_count)] : 0;
				end
				if (wait_left == 0) begin
					check("sink_req.we", 64'(sink_req.we), 64'd1);
					check("sink_req.adr", 64'(sink_req.adr), 64'(write_count));
					if (write_count < num_cores) begin
						dumped[core_idx_width'(write_count)] = sink_req.dat_w;
					end
					write_count++;
					sink_rsp.ack = 1'b1;
				end
				wait_left--;
			end
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (!run) begin
				check("sink_req.cyc", 64'(sink_req.cyc), 64'd0);
				check("sink_req.stb", 64'(sink_req.stb), 64'd0);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		report_failure("Timeout: the run did not finish within the watchdog limit");
	end

	initial begin : main
		logic [wb_dat_width-1:0] rdata;
		logic [frame_width-1:0] word;
		lfsr_state = 32'hdbb92964;
		reset = 1'b1;
		run = 1'b0;
		host_req = '0;
		prog_len = 0;
		for (int n = 0; n < num_programs; n++) begin
			reset = 1'b1;
			run = 1'b0;
			repeat (2) @(posedge clk);
			#1;
			reset = 1'b0;
			build_program();
			for (int w = 0; w < prog_len; w++) begin
				word = program_words[tm_addr_width'(w)];
				for (int h = 0; h < 2; h++) begin
					host_access(1'b1, wb_adr_width'(2 * w + h), word[32*h +: 32], rdata);
				end
			end
			for (int w = 0; w < prog_len; w++) begin
				word = program_words[tm_addr_width'(w)];
				for (int h = 0; h < 2; h++) begin
					host_access(1'b0, wb_adr_width'(2 * w + h), '0, rdata);
					check("host_rsp.dat_r", 64'(rdata), 64'(word[32*h +: 32]));
				end
			end
			for (int i = 0; i < num_cores; i++) ack_delay[i] = int'(rand_bits(3) % 6);
			run_model();
			run = 1'b1;
			while (write_count < num_cores) @(negedge clk);
			repeat (idle_cycles) @(posedge clk);
			#1;
			check("dump write count", 64'(write_count), 64'(num_cores));
			for (int i = 0; i < num_cores; i++) begin
				check("sink_req.dat_w", 64'(dumped[i]), 64'(model_r0[i]));
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/core_array_top.sv
`default_nettype none

module core_array_top
	import array_format_pkg::*, bus_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire run,
	input wire wb_req_t host_req,
	output wb_rsp_t host_rsp,
	output wb_req_t sink_req,
	input wire wb_rsp_t sink_rsp
);

	logic [tm_addr_width-1:0] frame_addr;
	task_frame_u frame;
	logic [num_cores-1:0] core_ready;
	logic [num_cores-1:0] core_start;
	insn_t insn;
	logic [num_cores-1:0] init_valid;
	logic [num_cores-1:0][reg_width-1:0] init_r0;
	logic [num_cores-1:0][reg_width-1:0] core_r0;
	logic dump_req;
	logic dump_done;

	task_memory u_memory (
		.clk,
		.reset,
		.host_req,
		.host_rsp,
		.frame_addr,
		.frame
	);

	task_scheduler u_scheduler (
		.clk,
		.reset,
		.run,
		.frame_addr,
		.frame,
		.core_ready,
		.core_start,
		.insn,
		.init_valid,
		.init_r0,
		.dump_req,
		.dump_done
	);

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		compute_core u_core (
			.clk,
			.reset,
			.start(core_start[i]),
			.insn,
			.init_valid(init_valid[i]),
			.init_r0(init_r0[i]),
			.ready(core_ready[i]),
			.r0(core_r0[i])
		);
	end

	result_dump u_dump (
		.clk,
		.reset,
		.dump_req,
		.core_r0,
		.sink_req,
		.sink_rsp,
		.dump_done
	);

endmodule

`default_nettype wire

//--- source/result_dump.sv
`default_nettype none

module result_dump
	import array_format_pkg::*, bus_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire dump_req,
	input wire [num_cores-1:0][reg_width-1:0] core_r0,
	output wb_req_t sink_req,
	input wire wb_rsp_t sink_rsp,
	output logic dump_done
);

	logic [num_cores-1:0][reg_width-1:0] captured;
	logic [core_idx_width-1:0] idx;
	logic active;
	logic stb_q;

	always_ff @(posedge clk) begin
		if (dump_req) begin
			captured <= core_r0; // Snapshot of every r0
		end
	end

	always_ff @(posedge clk) begin
		dump_done <= 1'b0;
		if (reset) begin
			active <= 1'b0;
			stb_q <= 1'b0;
			idx <= '0;
		end else if (dump_req) begin
			active <= 1'b1;
			stb_q <= 1'b1;
			idx <= '0;
		end else if (stb_q) begin
			if (sink_rsp.ack) begin
				stb_q <= 1'b0; // Idle cycle before the next write
				if (idx == core_idx_width'(num_cores - 1)) begin
					active <= 1'b0;
					dump_done <= 1'b1;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end else if (active) begin
			stb_q <= 1'b1;
		end
	end

	assign sink_req.cyc = stb_q;
	assign sink_req.stb = stb_q;
	assign sink_req.we = 1'b1;
	assign sink_req.adr = wb_adr_width'(idx);
	assign sink_req.dat_w = wb_dat_width'(captured[idx]);

	stb_held_until_ack: assert property (
		@(posedge clk) disable iff (reset)
		sink_req.stb && !sink_rsp.ack |=> sink_req.stb
	);

endmodule

`default_nettype wire

//--- source/compute_core.sv
`default_nettype none

module compute_core
	import array_format_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire insn_t insn,
	input wire init_valid,
	input wire [reg_width-1:0] init_r0,
	output logic ready,
	output logic [reg_width-1:0] r0
);

	insn_t [insn_parts-1:0] insn_buf;
	logic [part_width-1:0] load_idx;
	logic [part_width-1:0] exec_idx;
	logic busy;

	function automatic logic [reg_width-1:0] execute(
		input logic [reg_width-1:0] value,
		input insn_t op
	);
		case (op.opcode)
			op_addi: return value + reg_width'(op.imm); // Wraps at reg_width
			op_xori: return value ^ reg_width'(op.imm);
			op_shl: return value << 1;
			default: return value;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (start) begin
			insn_buf[load_idx] <= insn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			load_idx <= '0;
			exec_idx <= '0;
			busy <= 1'b0;
			r0 <= '0;
		end else if (busy) begin
			r0 <= execute(r0, insn_buf[exec_idx]); // One instruction per cycle
			exec_idx <= exec_idx + 1'b1;
			if (exec_idx == part_width'(insn_parts - 1)) begin
				exec_idx <= '0;
				busy <= 1'b0;
			end
		end else begin
			if (init_valid) begin
				r0 <= init_r0;
			end
			if (start) begin
				load_idx <= load_idx + 1'b1;
				if (load_idx == part_width'(insn_parts - 1)) begin
					load_idx <= '0;
					busy <= 1'b1; // Buffer full
				end
			end
		end
	end

	assign ready = !busy;

	no_start_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		start |-> !busy
	);

endmodule

`default_nettype wire

//--- source/task_scheduler.sv
`default_nettype none

module task_scheduler
	import array_format_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire run,
	output logic [tm_addr_width-1:0] frame_addr,
	input wire task_frame_u frame,
	input wire [num_cores-1:0] core_ready,
	output logic [num_cores-1:0] core_start,
	output insn_t insn,
	output logic [num_cores-1:0] init_valid,
	output logic [num_cores-1:0][reg_width-1:0] init_r0,
	output logic dump_req,
	input wire dump_done
);

	control_frame_t ctrl;
	insn_frame_t insns;
	logic [tm_addr_width-1:0] task_ptr;
	logic [tm_addr_width-1:0] frame_count;
	logic [num_cores-1:0] active_mask;
	fence_t fence;
	logic stop_q;
	logic [tm_addr_width-1:0] stop_addr_q;
	logic [part_width-1:0] part_idx;
	logic dump_pending;
	logic dump_wait;
	logic all_ready;
	logic next_ready;
	logic strict;
	logic accept;
	logic stream;
	logic last_part;

	assign ctrl = frame.ctrl;
	assign insns = frame.insns;

	assign all_ready = &core_ready;
	assign next_ready = (core_ready & ctrl.active_mask) == ctrl.active_mask;
	assign strict = (fence == fence_acquire) || (ctrl.fence == fence_release);

	// Control frame gate
	assign accept = run && (frame_count == '0) && !dump_pending && !dump_wait &&
		(strict ? all_ready : next_ready);
	assign stream = (frame_count != '0) && ((core_ready & active_mask) == active_mask);
	assign last_part = part_idx == part_width'(insn_parts - 1);

	assign frame_addr = task_ptr;
	assign core_start = stream ? active_mask : '0;
	assign insn = insns.parts[part_idx];
	assign init_valid = accept ? ctrl.init_mask : '0;
	assign init_r0 = ctrl.init_r0;

	always_ff @(posedge clk) begin
		dump_req <= 1'b0;
		if (reset) begin
			task_ptr <= '0;
			frame_count <= '0;
			active_mask <= '0;
			fence <= fence_none;
			stop_q <= 1'b0;
			stop_addr_q <= '0;
			part_idx <= '0;
			dump_pending <= 1'b0;
			dump_wait <= 1'b0;
		end else if (accept) begin
			frame_count <= ctrl.frame_count;
			active_mask <= ctrl.active_mask;
			fence <= ctrl.fence;
			stop_q <= ctrl.stop;
			stop_addr_q <= ctrl.stop_addr;
			part_idx <= '0;
			if (ctrl.frame_count == '0 && ctrl.stop) begin
				task_ptr <= ctrl.stop_addr; // Plain jump, no dump
			end else begin
				task_ptr <= task_ptr + 1'b1;
			end
		end else if (stream) begin
			part_idx <= part_idx + 1'b1;
			if (last_part) begin
				part_idx <= '0;
				frame_count <= frame_count - 1'b1;
				if (frame_count == tm_addr_width'(1) && stop_q) begin
					task_ptr <= stop_addr_q;
					fence <= fence_acquire; // Next task waits for every core
					dump_pending <= 1'b1;
				end else begin
					task_ptr <= task_ptr + 1'b1;
				end
			end
		end else if (dump_pending && all_ready) begin
			dump_pending <= 1'b0;
			dump_wait <= 1'b1;
			dump_req <= 1'b1;
		end else if (dump_done) begin
			dump_wait <= 1'b0;
		end
	end

	// Parts reach only active cores and never during the dump pause
	start_only_active: assert property (
		@(posedge clk) disable iff (reset)
		core_start != '0 |->
			((core_start & ~active_mask) == '0) && !dump_pending && !dump_wait
	);

	dump_with_cores_idle: assert property (
		@(posedge clk) disable iff (reset)
		dump_req |-> all_ready
	);

endmodule

`default_nettype wire

//--- source/task_memory.sv
`default_nettype none

module task_memory
	import array_format_pkg::*, bus_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire wb_req_t host_req,
	output wb_rsp_t host_rsp,
	input wire [tm_addr_width-1:0] frame_addr,
	output task_frame_u frame
);

	// Entry index is {frame, half}, half 0 is the low word
	logic [wb_dat_width-1:0] mem [2*tm_depth];
	logic ack_q;
	logic [wb_dat_width-1:0] dat_q;
	logic hit;

	assign hit = host_req.cyc && host_req.stb && !ack_q; // New access seen

	always_ff @(posedge clk) begin
		if (hit && host_req.we) begin
			mem[host_req.adr] <= host_req.dat_w;
		end
		if (hit) begin
			dat_q <= mem[host_req.adr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	assign host_rsp = '{ack: ack_q, dat_r: dat_q};

	assign frame = {mem[{frame_addr, 1'b1}], mem[{frame_addr, 1'b0}]}; // Scheduler view

	// Each access gets exactly one ack cycle
	ack_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		host_rsp.ack |=> !host_rsp.ack
	);

endmodule

`default_nettype wire

//--- source/bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int wb_adr_width = 5;
	localparam int wb_dat_width = 32;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wb_adr_width-1:0] adr;
		logic [wb_dat_width-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [wb_dat_width-1:0] dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- source/array_format_pkg.sv
`default_nettype none

package array_format_pkg;

	localparam int num_cores = 4;
	localparam int insn_parts = 4;
	localparam int insn_width = 8;
	localparam int reg_width = 8;
	localparam int tm_depth = 16;
	localparam int tm_addr_width = 4;
	localparam int frame_width = 64;

	localparam int part_width = $clog2(insn_parts);
	localparam int core_idx_width = $clog2(num_cores);
	localparam int imm_width = insn_width - 2;

	// Bits in use by a control frame, the rest is padding
	localparam int ctrl_used_width =
		2 * tm_addr_width + 2 * num_cores + num_cores * reg_width + 3;
	localparam int ctrl_pad_width = frame_width - ctrl_used_width;
	localparam int insn_pad_width = frame_width - insn_parts * insn_width;

	typedef enum logic [1:0] {
		fence_none = 2'd0,
		fence_acquire = 2'd1,
		fence_release = 2'd2
	} fence_t;

	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_addi = 2'd1,
		op_xori = 2'd2,
		op_shl = 2'd3
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [imm_width-1:0] imm;
	} insn_t;

	typedef struct packed {
		logic [ctrl_pad_width-1:0] reserved;
		logic [tm_addr_width-1:0] stop_addr;
		logic stop;
		fence_t fence;
		logic [num_cores-1:0][reg_width-1:0] init_r0;
		logic [num_cores-1:0] init_mask;
		logic [num_cores-1:0] active_mask;
		logic [tm_addr_width-1:0] frame_count; // Instruction frames that follow
	} control_frame_t;

	typedef struct packed {
		logic [insn_pad_width-1:0] reserved;
		insn_t [insn_parts-1:0] parts; // Part 0 is streamed first
	} insn_frame_t;

	// Decoded by the scheduler according to its remaining frame count
	typedef union packed {
		control_frame_t ctrl;
		insn_frame_t insns;
	} task_frame_u;

endpackage

`default_nettype wire
